//--- alu_vectors.txt
// Columns, all hex: opcode, operand one (in1), operand two (in2), expected result
// Float words are sign[31], exponent[30:23] two's complement, mantissa[22:0]
00 11111111 22222222 22222222
01 11111111 22222222 11111111
02 7fffffff 00000001 80000000
02 12345678 87654321 99999999
04 00010001 00010001 00020001
04 fffffffe 00000003 fffffffa
0b 00000000 00000005 fffffffb
0b 00000000 80000000 80000000
0c 80000000 00000000 80000000
0c 00000001 00000000 ffffffff
0f 00000000 80000000 80000000
0f 00000000 fffffff6 0000000a
1d f0f0f0f0 ff00ff00 f000f000
1e f0f0f0f0 0f0f0000 fffff0f0
1f aaaaaaaa ffff0000 5555aaaa
20 00000000 0000ffff ffff0000
26 ffffffff 00000001 00000001
28 ffffffff 00000001 00000000
28 7fffffff 80000000 00000001
2a 12345678 12345678 00000001
2b 00000001 0000001f 80000000
2c 80000000 00000004 08000000
2d 80000000 00000004 f8000000
2d f0000000 00000024 ff000000
3f 12345678 87654321 00000000
03 12345678 87654321 00000000
0d 00000000 0a400000 8a400000
11 00000000 8a400000 0a400000
15 00000000 8a400000 40000000
15 00000000 0a400000 0a400000
05 00400000 00400000 0b400000
05 81400000 7e800100 83c00000
05 80000001 00000001 c0000000
05 3fc00000 3fc00000 0a400000

//--- project.f
alu_cfg_pkg.sv
float_pkg.sv
alu_pipe_ctrl.sv
int_unit.sv
float_unit.sv
float_norm.sv
result_stage.sv
alu_top.sv
tb_alu_top.sv

//--- run.sh
#!/bin/sh
# Compile the ALU testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	-f project.f --top-module tb_alu_top -o tb_alu_top
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/tb_alu_top
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi
exit 0

//--- tb_alu_top.sv
// Self-checking testbench for the two-stage pipelined ALU
// Streams the vector file twice, first back to back with the sink always ready,
// then with LFSR-driven gaps on in_valid and out_ready
// Expected results ride a queue from input transfer to output transfer

module tb_alu_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          max_vectors = 64;
	localparam logic [15:0] lfsr_seed   = 16'd20515;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic [5:0]  op;
	logic [31:0] in1;
	logic [31:0] in2;
	logic        out_ready;
	logic        in_ready;
	logic        out_valid;
	logic [31:0] result;

	logic [31:0] vec_mem [0:4*max_vectors-1];  // op, in1, in2, expected per test
	int          num_vectors;
	int          timeout_limit = 0;
	int          cycle_count   = 0;              // Edge number
	logic [15:0] lfsr_state;

	logic [31:0] exp_q[$];       // Expected results in flight
	int          accept_q[$];    // Edge of each input transfer
	int          send_idx;       // Next vector to offer
	int          recv_count;
	int          checked_total;
	bit          holding;        // Sink stalled a valid result at the last edge
	logic [31:0] held_result;

	alu_top alu_top_i (
		.clk, .rst_n, .in_valid, .op, .in1, .in2, .out_ready,
		.in_ready, .out_valid, .result
	);

	// ************************************************************************
	// Clock and watchdog
	// ************************************************************************

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;  // 8 ns period
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit > 0 && cycle_count >= timeout_limit)
			fail_run($sformatf("timeout after %0d cycles, %0d of %0d results checked",
				cycle_count, checked_total, 2 * num_vectors));
	end

	// ************************************************************************
	// Helpers
	// ************************************************************************

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
			fail_run($sformatf("mismatch at %0t: %s is %h, expected %h",
				$time, name, got, expected));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic bit random_bit();
		bit fb;
		fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
		lfsr_state = {lfsr_state[14:0], fb};
		return fb;
	endfunction

	task automatic load_vectors();
		for (int k = 0; k < 4 * max_vectors; k++)
			vec_mem[k] = ~32'(k);  // Top bits set, never an opcode
		$readmemh("alu_vectors.txt", vec_mem);
		num_vectors = 0;
		while (num_vectors < max_vectors && vec_mem[4*num_vectors] < 32'd64)
			num_vectors++;  // Opcodes fit in six bits
		if (num_vectors == 0)
			fail_run("no test vectors could be read from alu_vectors.txt");
		timeout_limit = 20 * num_vectors + 50;
	endtask

	// ************************************************************************
	// Sample, check and drive once per clock cycle
	// ************************************************************************

	task automatic step(input bit random_mode);
		bit offer;
		bit ready;
		int accepted_at;
		@(posedge clk);
		// Values read here held up to this edge
		if (holding) begin
			check_value("out_valid", 32'(out_valid), 32'd1);  // No drop during stall
			check_value("result", result, held_result);      // Frozen while stalled
		end
		if (out_valid && out_ready) begin
			if (exp_q.size() == 0)
				fail_run("a result was accepted with no operation in flight");
			check_value("result", result, exp_q.pop_front());
			accepted_at = accept_q.pop_front();
			// Stage one at the accepting edge, stage two at the next
			if (!random_mode)
				check_value("result latency", 32'(cycle_count - accepted_at), 32'd2);
			recv_count++;
			checked_total++;
		end
		holding     = out_valid && !out_ready;
		held_result = result;
		if (!random_mode && in_valid)
			check_value("in_ready", 32'(in_ready), 32'd1);  // One per cycle
		if (in_valid && in_ready) begin
			exp_q.push_back(vec_mem[4*send_idx+3]);
			accept_q.push_back(cycle_count);
			send_idx++;
		end

		if (random_mode) begin
			offer = random_bit();
			ready = random_bit();
		end else begin
			offer = 1'b1;
			ready = 1'b1;
		end
		// A refused offer stays up with the same payload
		if (!in_valid || in_ready) begin
			if (send_idx < num_vectors && offer) begin
				in_valid <= 1'b1;
				op       <= vec_mem[4*send_idx][5:0];
				in1      <= vec_mem[4*send_idx+1];
				in2      <= vec_mem[4*send_idx+2];
			end else begin
				in_valid <= 1'b0;
			end
		end
		out_ready <= ready;
	endtask

	task automatic run_phase(input bit random_mode);
		send_idx   = 0;
		recv_count = 0;
		while (recv_count < num_vectors)
			step(random_mode);
	endtask

	// ************************************************************************
	// Main sequence
	// ************************************************************************

	initial begin
		rst_n         = 1'b0;
		in_valid      = 1'b0;
		op            = '0;
		in1           = '0;
		in2           = '0;
		out_ready     = 1'b0;
		lfsr_state    = lfsr_seed;
		holding       = 1'b0;
		held_result   = '0;
		checked_total = 0;
		load_vectors();

		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		// Pipeline empty and sink not ready yet
		check_value("out_valid", 32'(out_valid), 32'd0);
		check_value("in_ready", 32'(in_ready), 32'd1);

		out_ready <= 1'b1;
		run_phase(1'b0);  // Back to back
		run_phase(1'b1);  // Random gaps and stalls

		if (checked_total == 2 * num_vectors && exp_q.size() == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			fail_run("run ended with results left unchecked");
		end
	end

endmodule

//--- alu_top.sv
// Top level of the two-stage pipelined ALU with valid/ready at both ends
// Every accepted operation comes out two advancing cycles later, in order

module alu_top (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  alu_cfg_pkg::op_t     op,
	input  float_pkg::alu_word_t in1,
	input  float_pkg::alu_word_t in2,
	input  logic                 out_ready,
	output logic                 in_ready,
	output logic                 out_valid,
	output float_pkg::alu_word_t result
);

	import float_pkg::*;

	logic      advance;      // Common pipeline enable
	logic      s1_valid;
	logic      s1_is_float;
	logic      norm_req;
	alu_word_t int_result;
	alu_word_t float_raw;

	// Control keeps its own stage two valid for the stall
	alu_pipe_ctrl alu_pipe_ctrl_i (
		.clk, .rst_n, .in_valid, .op, .out_ready, .in_ready, .advance,
		.s1_valid, .out_valid (), .s1_op (), .s1_is_float
	);

	int_unit int_unit_i (
		.clk, .advance, .op, .in1, .in2, .int_result
	);

	float_unit float_unit_i (
		.clk, .advance, .op, .in1, .in2, .float_raw, .norm_req
	);

	result_stage result_stage_i (
		.clk, .rst_n, .advance, .s1_valid, .s1_is_float, .norm_req,
		.int_result, .float_raw, .out_valid, .result
	);

endmodule

//--- result_stage.sv
// Stage two output register of the ALU
// Picks the integer, raw float or normalized float result and holds out_valid

module result_stage (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 advance,
	input  logic                 s1_valid,
	input  logic                 s1_is_float,
	input  logic                 norm_req,
	input  float_pkg::alu_word_t int_result,
	input  float_pkg::alu_word_t float_raw,
	output logic                 out_valid,
	output float_pkg::alu_word_t result
);

	import float_pkg::*;

	alu_word_t normalized;  // F_MLT path
	alu_word_t next;

	float_norm float_norm_i (
		.raw        (float_raw),
		.normalized (normalized)
	);

	// ************************************************************************
	// Result select
	// ************************************************************************

	always_comb begin
		if (norm_req)
			next = normalized;
		else if (s1_is_float)
			next = float_raw;  // Sign only ops
		else
			next = int_result;
	end

	// Held while the sink stalls since advance is low
	always_ff @(posedge clk) begin
		if (advance)
			result <= next;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (advance)
			out_valid <= s1_valid;
	end

endmodule

//--- float_norm.sv
// Combinational normalizer for the custom float
// Shifts the mantissa up until its top bit is set and adjusts the exponent

module float_norm (
	input  float_pkg::alu_word_t raw,
	output float_pkg::alu_word_t normalized
);

	import float_pkg::*;

	localparam int unsigned lz_bits = $clog2(man_bits);

	logic [lz_bits-1:0] lz;        // Leading zero count
	logic               man_zero;

	assign man_zero = (raw.f.man == '0);

	// ************************************************************************
	// Leading zero count by priority from the top bit down
	// ************************************************************************

	always_comb begin
		logic found;
		found = 1'b0;
		lz    = '0;
		for (int i = man_bits - 1; i >= 0; i--) begin
			if (!found && raw.f.man[i]) begin
				lz    = lz_bits'(man_bits - 1 - i);
				found = 1'b1;
			end
		end
	end

	// ************************************************************************
	// Shift and exponent fix
	// ************************************************************************

	always_comb begin
		normalized.f.sign = raw.f.sign;  // Sign always kept
		if (man_zero) begin
			// Zero goes to the smallest exponent
			normalized.f.exp = float_zero.f.exp;
			normalized.f.man = '0;
		end else begin
			normalized.f.exp = raw.f.exp - exp_bits'(lz);  // Wraps
			normalized.f.man = raw.f.man << lz;
		end
	end

endmodule

//--- float_unit.sv
// Stage one of the float datapath
// Registers sign, exponent and mantissa results and flags F_MLT for normalizing

module float_unit (
	input  logic                 clk,
	input  logic                 advance,
	input  alu_cfg_pkg::op_t     op,
	input  float_pkg::alu_word_t in1,
	input  float_pkg::alu_word_t in2,
	output float_pkg::alu_word_t float_raw,
	output logic                 norm_req
);

	import alu_cfg_pkg::*;
	import float_pkg::*;

	logic        [2*man_bits-1:0] mlt_prod;  // Full mantissa product
	logic signed [exp_bits-1:0]   mlt_exp;
	alu_word_t                    next;

	// Product keeps the top half, so the exponent grows by man_bits
	assign mlt_prod = in1.f.man * in2.f.man;
	assign mlt_exp  = in1.f.exp + in2.f.exp + exp_bits'(man_bits);  // Wraps

	always_comb begin
		next = '0;
		case (op)
			op_f_neg: begin
				next        = in2;
				next.f.sign = ~in2.f.sign;
			end
			op_f_abs: begin
				next        = in2;
				next.f.sign = 1'b0;
			end
			op_f_pst: next = in2.f.sign ? float_zero : in2;  // Clamp negatives
			op_f_mlt: begin
				next.f.sign = in1.f.sign ^ in2.f.sign;
				next.f.exp  = mlt_exp;
				next.f.man  = mlt_prod[2*man_bits-1:man_bits];
			end
			default: next = '0;
		endcase
	end

	// ************************************************************************
	// Stage one register
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (advance) begin
			float_raw <= next;
			norm_req  <= (op == op_f_mlt);  // Only the product needs it
		end
	end

endmodule

//--- int_unit.sv
// Stage one of the integer datapath
// Decodes the opcode and registers integer, logic, shift and compare results

module int_unit (
	input  logic                clk,
	input  logic                advance,
	input  alu_cfg_pkg::op_t    op,
	input  float_pkg::alu_word_t in1,
	input  float_pkg::alu_word_t in2,
	output float_pkg::alu_word_t int_result
);

	import alu_cfg_pkg::*;
	import float_pkg::*;

	alu_word_t       next;   // Combinational result
	logic      [4:0] shamt;  // Shift amount

	assign shamt = in2.i[4:0];

	// ************************************************************************
	// Operation decode
	// ************************************************************************

	always_comb begin
		next.i = '0;  // Unknown and float opcodes give zero
		case (op)
			// Pass
			op_nop: next = in2;
			op_lod: next = in1;

			// Arithmetic wrapping at the word width
			op_add:   next.i = in1.i + in2.i;
			op_mlt:   next.i = in1.i * in2.i;  // Low word only
			op_neg:   next.i = -in2.i;
			op_neg_m: next.i = -in1.i;
			op_abs: begin
				if (in2.i[word_bits-1])
					next.i = -in2.i;  // Most negative stays put
				else
					next.i = in2.i;
			end

			// Bitwise
			op_and: next.i = in1.i & in2.i;
			op_orr: next.i = in1.i | in2.i;
			op_xor: next.i = in1.i ^ in2.i;
			op_inv: next.i = ~in2.i;

			// Signed compares
			op_les: next.i = word_bits'(in1.i < in2.i);
			op_gre: next.i = word_bits'(in1.i > in2.i);
			op_equ: next.i = word_bits'(in1.i == in2.i);

			// Shifts
			op_shl: next.i = in1.i << shamt;
			op_shr: next.i = in1.i >> shamt;
			op_srs: next.i = in1.i >>> shamt;  // Sign fill

			default: next.i = '0;
		endcase
	end

	// ************************************************************************
	// Stage one register
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (advance)
			int_result <= next;
	end

endmodule

//--- alu_pipe_ctrl.sv
// Handshake and stall control of the two-stage ALU pipeline
// Produces the single advance enable used by every pipeline register

module alu_pipe_ctrl (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  alu_cfg_pkg::op_t   op,
	input  logic               out_ready,
	output logic               in_ready,
	output logic               advance,
	output logic               s1_valid,
	output logic               out_valid,
	output alu_cfg_pkg::op_t   s1_op,
	output logic               s1_is_float
);

	import alu_cfg_pkg::*;

	logic is_float;  // Decoded at the input

	// ************************************************************************
	// Stall decision
	// ************************************************************************

	// Move when the output slot is free or being drained
	assign advance  = !out_valid || out_ready;
	assign in_ready = advance;

	assign is_float = op inside {op_f_neg, op_f_abs, op_f_pst, op_f_mlt};

	// ************************************************************************
	// Valid bits
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid  <= 1'b0;
			out_valid <= 1'b0;
		end else if (advance) begin
			s1_valid  <= in_valid;  // in_ready is advance here
			out_valid <= s1_valid;  // Stage two copy for the stall
		end
	end

	// Stage one opcode and format flag
	always_ff @(posedge clk) begin
		if (advance) begin
			s1_op       <= op;
			s1_is_float <= is_float;
		end
	end

endmodule

//--- float_pkg.sv
// Custom float format and the dual-view data word of the ALU
// A word is read as a signed integer or as sign/exponent/mantissa fields

package float_pkg;

	// ************************************************************************
	// Float layout
	// ************************************************************************

	// No hidden bit; value = signed mantissa * 2^exp
	localparam int unsigned man_bits = 23;
	localparam int unsigned exp_bits = 8;   // Two's complement exponent

	typedef struct packed {
		logic                       sign;  // 1 = negative
		logic signed [exp_bits-1:0] exp;
		logic        [man_bits-1:0] man;
	} float_fields_t;

	// ************************************************************************
	// Data word
	// ************************************************************************

	// Integer ops use .i, float ops use .f
	typedef union packed {
		logic signed [alu_cfg_pkg::word_bits-1:0] i;
		float_fields_t                           f;
	} alu_word_t;

	// Normalized zero
	// Sign 0, most negative exponent, empty mantissa
	localparam alu_word_t float_zero = {1'b0, 8'h80, 23'h0};

endpackage

//--- alu_cfg_pkg.sv
// Opcode map and word width of the pipelined ALU
// Imported by every RTL block that decodes or carries an opcode

package alu_cfg_pkg;

	// ************************************************************************
	// Widths
	// ************************************************************************

	localparam int unsigned word_bits = 32;  // One data word
	localparam int unsigned op_bits   = 6;   // Opcode field

	typedef logic [op_bits-1:0] op_t;

	// ************************************************************************
	// Opcodes
	// ************************************************************************

	// Pass and load
	localparam op_t op_nop   = 6'd0;   // Passes in2
	localparam op_t op_lod   = 6'd1;   // Passes in1

	// Two-operand arithmetic
	localparam op_t op_add   = 6'd2;
	localparam op_t op_mlt   = 6'd4;   // Low word of product
	localparam op_t op_f_mlt = 6'd5;   // Float product, normalized

	// One-operand arithmetic
	localparam op_t op_neg   = 6'd11;  // Negates in2
	localparam op_t op_neg_m = 6'd12;  // Negates in1
	localparam op_t op_f_neg = 6'd13;
	localparam op_t op_abs   = 6'd15;
	localparam op_t op_f_abs = 6'd17;
	localparam op_t op_f_pst = 6'd21;  // Float clamp to zero

	// Bitwise
	localparam op_t op_and   = 6'd29;
	localparam op_t op_orr   = 6'd30;
	localparam op_t op_xor   = 6'd31;
	localparam op_t op_inv   = 6'd32;

	// Signed compares giving 1 or 0
	localparam op_t op_les   = 6'd38;
	localparam op_t op_gre   = 6'd40;
	localparam op_t op_equ   = 6'd42;

	// Shifts by the low bits of in2
	localparam op_t op_shl   = 6'd43;
	localparam op_t op_shr   = 6'd44;
	localparam op_t op_srs   = 6'd45;  // Arithmetic right

endpackage
